// ==== rtl/mips_pipe_settings.svh ====
`ifndef MIPS_PIPE_SETTINGS_SVH
`define MIPS_PIPE_SETTINGS_SVH

// **************************************************
// Core widths
// **************************************************

// Data, address and instruction width.
`define MIPS_WORD_W 32

// Register index width for 32 registers.
`define MIPS_REG_ADDR_W 5

// **************************************************
// Fetch
// **************************************************

// First fetch address after reset.
`define MIPS_RESET_PC 32'h0000_0000

`endif

// ==== rtl/mips_pipe_pkg.sv ====
`default_nettype none

`include "mips_pipe_settings.svh"

package mips_pipe_pkg;
	typedef logic [`MIPS_WORD_W-1:0] word_t;
	typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// Primary opcodes of the subset.
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_BEQ   = 6'h04;
	localparam opcode_t OP_ADDIU = 6'h09;
	localparam opcode_t OP_LUI   = 6'h0f;
	localparam opcode_t OP_LW    = 6'h23;
	localparam opcode_t OP_SW    = 6'h2b;

	// R-type function codes.
	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND  = 6'h24;
	localparam funct_t FN_OR   = 6'h25;
	localparam funct_t FN_SLT  = 6'h2a;

	// Zero encodings make a cleared wall a no-op.
	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		SLT
	} alu_op_t;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_IMM
	} wb_sel_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic    use_imm;
	} ex_ctrl_t;

	typedef struct packed {
		logic dm_read;
		logic dm_write;
	} mem_ctrl_t;

	typedef struct packed {
		logic    reg_write;
		wb_sel_t wb_sel;
	} wb_ctrl_t;

	// **************************************************
	// Stage walls
	// **************************************************

	typedef struct packed {
		word_t instr;
		word_t pc_plus4;
	} if_id_t;

	typedef struct packed {
		word_t     ra_data;
		word_t     rt_data;
		word_t     alu_src2;
		word_t     imm;
		reg_addr_t dest;
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} id_ex_t;

	typedef struct packed {
		word_t     alu_result;
		word_t     rt_data;
		word_t     imm;
		reg_addr_t dest;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} ex_mem_t;

	typedef struct packed {
		logic      reg_write;
		reg_addr_t dest;
		word_t     wb_data;
	} mem_wb_t;
endpackage

`default_nettype wire

// ==== rtl/pipe_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_control (
	input  mips_pipe_pkg::if_id_t    instr,
	input  mips_pipe_pkg::reg_addr_t ex_dest,
	input  mips_pipe_pkg::wb_ctrl_t  ex_wb,
	input  mips_pipe_pkg::reg_addr_t mem_dest,
	input  mips_pipe_pkg::wb_ctrl_t  mem_wb,
	input  mips_pipe_pkg::reg_addr_t wb_dest,
	input  logic                     wb_we,
	input  logic                     operands_equal,
	output mips_pipe_pkg::ex_ctrl_t  ex_ctrl,
	output mips_pipe_pkg::mem_ctrl_t mem_ctrl,
	output mips_pipe_pkg::wb_ctrl_t  wb_ctrl,
	output logic                     dest_is_rt,
	output logic                     sign_ext,
	output logic                     hazard,
	output logic                     flush
);
	mips_pipe_pkg::opcode_t   opcode;
	mips_pipe_pkg::funct_t    funct;
	mips_pipe_pkg::reg_addr_t rs;
	mips_pipe_pkg::reg_addr_t rt;
	logic                     reads_rt;
	logic                     is_beq;
	logic                     rs_hit;
	logic                     rt_hit;

	assign opcode = instr.instr[31:26];
	assign funct  = instr.instr[5:0];
	assign rs     = instr.instr[25:21];
	assign rt     = instr.instr[20:16];

	// **************************************************
	// Instruction decode
	// **************************************************

	always_comb begin
		ex_ctrl    = '0;
		mem_ctrl   = '0;
		wb_ctrl    = '0;
		dest_is_rt = 1'b1;
		sign_ext   = 1'b1;
		reads_rt   = 1'b0;
		is_beq     = 1'b0;
		case (opcode)
			mips_pipe_pkg::OP_RTYPE: begin
				dest_is_rt        = 1'b0;
				reads_rt          = 1'b1;
				wb_ctrl.reg_write = 1'b1;
				case (funct)
					mips_pipe_pkg::FN_ADDU: ex_ctrl.alu_op = mips_pipe_pkg::ADD;
					mips_pipe_pkg::FN_SUBU: ex_ctrl.alu_op = mips_pipe_pkg::SUB;
					mips_pipe_pkg::FN_AND:  ex_ctrl.alu_op = mips_pipe_pkg::AND;
					mips_pipe_pkg::FN_OR:   ex_ctrl.alu_op = mips_pipe_pkg::OR;
					mips_pipe_pkg::FN_SLT:  ex_ctrl.alu_op = mips_pipe_pkg::SLT;
					// Unknown funct such as the all-zero word.
					default: wb_ctrl.reg_write = 1'b0;
				endcase
			end
			mips_pipe_pkg::OP_ADDIU: begin
				ex_ctrl.use_imm   = 1'b1;
				wb_ctrl.reg_write = 1'b1;
			end
			mips_pipe_pkg::OP_LUI: begin
				sign_ext          = 1'b0;
				wb_ctrl.reg_write = 1'b1;
				wb_ctrl.wb_sel    = mips_pipe_pkg::WB_IMM;
			end
			mips_pipe_pkg::OP_LW: begin
				ex_ctrl.use_imm   = 1'b1;
				mem_ctrl.dm_read  = 1'b1;
				wb_ctrl.reg_write = 1'b1;
				wb_ctrl.wb_sel    = mips_pipe_pkg::WB_MEM;
			end
			mips_pipe_pkg::OP_SW: begin
				ex_ctrl.use_imm   = 1'b1;
				mem_ctrl.dm_write = 1'b1;
				reads_rt          = 1'b1;
			end
			mips_pipe_pkg::OP_BEQ: begin
				reads_rt = 1'b1;
				is_beq   = 1'b1;
			end
			default: ;
		endcase
	end

	// **************************************************
	// Stall and redirect
	// **************************************************

	// A source is pending while any later stage still has to write it.
	assign rs_hit = (rs != '0) &&
		((ex_wb.reg_write && rs == ex_dest) ||
		 (mem_wb.reg_write && rs == mem_dest) ||
		 (wb_we && rs == wb_dest));

	assign rt_hit = reads_rt && (rt != '0) &&
		((ex_wb.reg_write && rt == ex_dest) ||
		 (mem_wb.reg_write && rt == mem_dest) ||
		 (wb_we && rt == wb_dest));

	assign hazard = rs_hit || rt_hit;

	// Compare is only valid once both operands are current.
	assign flush = is_beq && operands_equal && !hazard;
endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_pipe_settings.svh"

module fetch_unit (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic                 run,
	input  logic                 hold,
	input  logic                 redirect,
	input  mips_pipe_pkg::word_t target,
	output mips_pipe_pkg::word_t pc,
	output mips_pipe_pkg::word_t pc_plus4
);
	assign pc_plus4 = pc + mips_pipe_pkg::word_t'(4);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc <= `MIPS_RESET_PC;
		end else if (run) begin
			// Redirect never coincides with hold.
			if (redirect) begin
				pc <= target;
			end else if (!hold) begin
				pc <= pc_plus4;
			end
		end
	end
endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_pipe_settings.svh"

module reg_file (
	input  logic                     clock,
	input  logic                     arst_n,
	input  logic                     we,
	input  mips_pipe_pkg::reg_addr_t waddr,
	input  mips_pipe_pkg::word_t     wdata,
	input  mips_pipe_pkg::reg_addr_t raddr_a,
	input  mips_pipe_pkg::reg_addr_t raddr_b,
	output mips_pipe_pkg::word_t     rdata_a,
	output mips_pipe_pkg::word_t     rdata_b
);
	localparam int DEPTH = 1 << `MIPS_REG_ADDR_W;

	mips_pipe_pkg::word_t regs [DEPTH];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// r0 reads as zero.
	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];
endmodule

`default_nettype wire

// ==== rtl/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
	input  logic                   clock,
	input  logic                   arst_n,
	input  mips_pipe_pkg::if_id_t  if_id,
	input  logic                   dest_is_rt,
	input  logic                   sign_ext,
	input  logic                   use_imm,
	input  mips_pipe_pkg::mem_wb_t wb,
	input  logic                   run,
	output mips_pipe_pkg::id_ex_t  ex_payload,
	output logic                   operands_equal,
	output mips_pipe_pkg::word_t   branch_target
);
	mips_pipe_pkg::word_t ra_data;
	mips_pipe_pkg::word_t rt_data;
	mips_pipe_pkg::word_t imm;
	mips_pipe_pkg::word_t offset;

	reg_file u_reg_file (
		.clock   (clock),
		.arst_n  (arst_n),
		.we      (wb.reg_write && run),
		.waddr   (wb.dest),
		.wdata   (wb.wb_data),
		.raddr_a (if_id.instr[25:21]),
		.raddr_b (if_id.instr[20:16]),
		.rdata_a (ra_data),
		.rdata_b (rt_data)
	);

	// Only lui clears sign_ext.
	always_comb begin
		if (sign_ext) begin
			imm = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
		end else begin
			imm = {if_id.instr[15:0], 16'h0000};
		end
	end

	// Control bundles are merged in at the top level.
	always_comb begin
		ex_payload          = '0;
		ex_payload.ra_data  = ra_data;
		ex_payload.rt_data  = rt_data;
		ex_payload.imm      = imm;
		ex_payload.alu_src2 = use_imm ? imm : rt_data;
		ex_payload.dest     = dest_is_rt ? if_id.instr[20:16] : if_id.instr[15:11];
	end

	// Branch target is a word offset from pc+4.
	assign offset         = {{14{if_id.instr[15]}}, if_id.instr[15:0], 2'b00};
	assign branch_target  = if_id.pc_plus4 + offset;
	assign operands_equal = ra_data == rt_data;
endmodule

`default_nettype wire

// ==== rtl/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  mips_pipe_pkg::id_ex_t  id_ex,
	input  mips_pipe_pkg::ex_mem_t ex_mem,
	input  mips_pipe_pkg::word_t   dm_rdata,
	output mips_pipe_pkg::word_t   alu_result,
	output mips_pipe_pkg::word_t   wb_data
);
	logic less;

	assign less = $signed(id_ex.ra_data) < $signed(id_ex.alu_src2);

	// **************************************************
	// ALU on the REG2 side
	// **************************************************

	always_comb begin
		case (id_ex.ex.alu_op)
			mips_pipe_pkg::ADD: alu_result = id_ex.ra_data + id_ex.alu_src2;
			mips_pipe_pkg::SUB: alu_result = id_ex.ra_data - id_ex.alu_src2;
			mips_pipe_pkg::AND: alu_result = id_ex.ra_data & id_ex.alu_src2;
			mips_pipe_pkg::OR:  alu_result = id_ex.ra_data | id_ex.alu_src2;
			mips_pipe_pkg::SLT: alu_result = mips_pipe_pkg::word_t'(less);
			default:            alu_result = '0;
		endcase
	end

	// **************************************************
	// Writeback select on the REG3 side
	// **************************************************

	always_comb begin
		case (ex_mem.wb.wb_sel)
			mips_pipe_pkg::WB_MEM: wb_data = dm_rdata;
			mips_pipe_pkg::WB_IMM: wb_data = ex_mem.imm;
			default:               wb_data = ex_mem.alu_result;
		endcase
	end
endmodule

`default_nettype wire

// ==== rtl/pipe_regwalls.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_regwalls (
	input  logic                   clock,
	input  logic                   arst_n,
	input  logic                   run,
	input  logic                   hazard,
	input  logic                   flush,
	input  mips_pipe_pkg::if_id_t  if_id_in,
	input  mips_pipe_pkg::id_ex_t  id_ex_in,
	input  mips_pipe_pkg::word_t   alu_result,
	input  mips_pipe_pkg::word_t   wb_data,
	output mips_pipe_pkg::if_id_t  if_id,
	output mips_pipe_pkg::id_ex_t  id_ex,
	output mips_pipe_pkg::ex_mem_t ex_mem,
	output mips_pipe_pkg::mem_wb_t mem_wb
);
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			if_id  <= '0;
			id_ex  <= '0;
			ex_mem <= '0;
			mem_wb <= '0;
		end else if (run) begin
			// Hold on REG1 beats flush.
			if (hazard) begin
				if_id <= if_id;
			end else if (flush) begin
				if_id <= '0;
			end else begin
				if_id <= if_id_in;
			end

			// REG2 takes a bubble while decode stalls.
			if (hazard) begin
				id_ex <= '0;
			end else begin
				id_ex <= id_ex_in;
			end

			// REG3 and REG4 never stall.
			ex_mem <= '{
				alu_result: alu_result,
				rt_data:    id_ex.rt_data,
				imm:        id_ex.imm,
				dest:       id_ex.dest,
				mem:        id_ex.mem,
				wb:         id_ex.wb
			};

			mem_wb <= '{
				reg_write: ex_mem.wb.reg_write,
				dest:      ex_mem.dest,
				wb_data:   wb_data
			};
		end
	end
endmodule

`default_nettype wire

// ==== rtl/mips_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_pipe (
	input  logic                     clock,
	input  logic                     arst_n,
	input  logic                     run,
	output mips_pipe_pkg::word_t     imem_addr,
	input  mips_pipe_pkg::word_t     imem_data,
	output mips_pipe_pkg::word_t     dm_addr,
	output mips_pipe_pkg::word_t     dm_wdata,
	output logic                     dm_read,
	output logic                     dm_write,
	input  mips_pipe_pkg::word_t     dm_rdata,
	output logic                     wb_we,
	output mips_pipe_pkg::reg_addr_t wb_addr,
	output mips_pipe_pkg::word_t     wb_data
);
	mips_pipe_pkg::if_id_t    if_id_in;
	mips_pipe_pkg::if_id_t    if_id;
	mips_pipe_pkg::id_ex_t    payload;
	mips_pipe_pkg::id_ex_t    id_ex_in;
	mips_pipe_pkg::id_ex_t    id_ex;
	mips_pipe_pkg::ex_mem_t   ex_mem;
	mips_pipe_pkg::mem_wb_t   mem_wb;
	mips_pipe_pkg::ex_ctrl_t  ex_ctrl;
	mips_pipe_pkg::mem_ctrl_t mem_ctrl;
	mips_pipe_pkg::wb_ctrl_t  wb_ctrl;
	mips_pipe_pkg::word_t     pc_plus4;
	mips_pipe_pkg::word_t     branch_target;
	mips_pipe_pkg::word_t     alu_result;
	mips_pipe_pkg::word_t     wb_value;
	logic                     dest_is_rt;
	logic                     sign_ext;
	logic                     hazard;
	logic                     flush;
	logic                     operands_equal;

	assign if_id_in = '{instr: imem_data, pc_plus4: pc_plus4};

	assign id_ex_in = '{
		ra_data:  payload.ra_data,
		rt_data:  payload.rt_data,
		alu_src2: payload.alu_src2,
		imm:      payload.imm,
		dest:     payload.dest,
		ex:       ex_ctrl,
		mem:      mem_ctrl,
		wb:       wb_ctrl
	};

	fetch_unit u_fetch (
		.clock    (clock),
		.arst_n   (arst_n),
		.run      (run),
		.hold     (hazard),
		.redirect (flush),
		.target   (branch_target),
		.pc       (imem_addr),
		.pc_plus4 (pc_plus4)
	);

	pipe_control u_control (
		.instr          (if_id),
		.ex_dest        (id_ex.dest),
		.ex_wb          (id_ex.wb),
		.mem_dest       (ex_mem.dest),
		.mem_wb         (ex_mem.wb),
		.wb_dest        (mem_wb.dest),
		.wb_we          (mem_wb.reg_write),
		.operands_equal (operands_equal),
		.ex_ctrl        (ex_ctrl),
		.mem_ctrl       (mem_ctrl),
		.wb_ctrl        (wb_ctrl),
		.dest_is_rt     (dest_is_rt),
		.sign_ext       (sign_ext),
		.hazard         (hazard),
		.flush          (flush)
	);

	decode_unit u_decode (
		.clock          (clock),
		.arst_n         (arst_n),
		.if_id          (if_id),
		.dest_is_rt     (dest_is_rt),
		.sign_ext       (sign_ext),
		.use_imm        (ex_ctrl.use_imm),
		.wb             (mem_wb),
		.run            (run),
		.ex_payload     (payload),
		.operands_equal (operands_equal),
		.branch_target  (branch_target)
	);

	exec_unit u_exec (
		.id_ex      (id_ex),
		.ex_mem     (ex_mem),
		.dm_rdata   (dm_rdata),
		.alu_result (alu_result),
		.wb_data    (wb_value)
	);

	pipe_regwalls u_walls (
		.clock      (clock),
		.arst_n     (arst_n),
		.run        (run),
		.hazard     (hazard),
		.flush      (flush),
		.if_id_in   (if_id_in),
		.id_ex_in   (id_ex_in),
		.alu_result (alu_result),
		.wb_data    (wb_value),
		.if_id      (if_id),
		.id_ex      (id_ex),
		.ex_mem     (ex_mem),
		.mem_wb     (mem_wb)
	);

	// Memory port from REG3.
	assign dm_addr  = ex_mem.alu_result;
	assign dm_wdata = ex_mem.rt_data;
	assign dm_read  = ex_mem.mem.dm_read;
	assign dm_write = ex_mem.mem.dm_write;

	// Writeback port from REG4.
	assign wb_we   = mem_wb.reg_write;
	assign wb_addr = mem_wb.dest;
	assign wb_data = mem_wb.wb_data;
endmodule

`default_nettype wire

// ==== tests/mips_pipe_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_pipe_asserts (
	input logic                     clock,
	input logic                     arst_n,
	input logic                     hazard,
	input logic                     dm_read,
	input logic                     dm_write,
	input logic                     wb_we,
	input mips_pipe_pkg::reg_addr_t wb_addr,
	input mips_pipe_pkg::word_t     imem_addr
);
	strobes_exclusive: assert property (@(posedge clock) disable iff (!arst_n)
		!(dm_read && dm_write))
		else $error("dm_read and dm_write high in the same cycle");

	no_r0_write: assert property (@(posedge clock) disable iff (!arst_n)
		wb_we |-> wb_addr != '0)
		else $error("writeback port shows a write to r0");

	// Walls are cleared while reset is held.
	quiet_in_reset: assert property (@(posedge clock)
		!arst_n |-> !dm_read && !dm_write && !wb_we)
		else $error("memory or writeback strobe high during reset");

	pc_holds_on_stall: assert property (@(posedge clock) disable iff (!arst_n)
		hazard |=> $stable(imem_addr))
		else $error("fetch address moved in the cycle after a hazard");
endmodule

`default_nettype wire

// ==== tests/mips_pipe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_pipe_tb;
	localparam int NUM_TESTS = 6;
	localparam int MAX_LEN = 64;
	localparam int LENS [NUM_TESTS] = '{24, 24, 28, 28, 28, 32};
	localparam int NREGS [NUM_TESTS] = '{7, 7, 7, 2, 4, 7};
	// Mix bits from bit 0 are R-type, addiu, lui, lw, sw and beq.
	localparam logic [7:0] MIXES [NUM_TESTS] = '{8'h01, 8'h07, 8'h1b, 8'h1f, 8'h23, 8'h3f};

	logic                     clock;
	logic                     arst_n;
	logic                     run;
	mips_pipe_pkg::word_t     imem_addr;
	mips_pipe_pkg::word_t     imem_data;
	mips_pipe_pkg::word_t     dm_addr;
	mips_pipe_pkg::word_t     dm_wdata;
	mips_pipe_pkg::word_t     dm_rdata;
	logic                     dm_read;
	logic                     dm_write;
	logic                     wb_we;
	mips_pipe_pkg::reg_addr_t wb_addr;
	mips_pipe_pkg::word_t     wb_data;

	mips_pipe_pkg::word_t     prog [MAX_LEN];
	mips_pipe_pkg::word_t     data_init [16];
	mips_pipe_pkg::word_t     data_mem [16];
	mips_pipe_pkg::reg_addr_t exp_wb_addr [$];
	mips_pipe_pkg::word_t     exp_wb_data [$];
	mips_pipe_pkg::word_t     exp_st_addr [$];
	mips_pipe_pkg::word_t     exp_st_data [$];
	mips_pipe_pkg::word_t     exp_ld_addr [$];
	logic [31:0]              lfsr_state;
	string                    test_name;
	int                       prog_len = 0;
	int                       wb_seen = 0;
	int                       st_seen = 0;
	int                       ld_seen = 0;
	int                       cycles = 0;
	int                       limit = 0;
	int                       errors = 0;
	int                       end_errors = 0;

	mips_pipe DUT (
		.clock     (clock),
		.arst_n    (arst_n),
		.run       (run),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.dm_addr   (dm_addr),
		.dm_wdata  (dm_wdata),
		.dm_read   (dm_read),
		.dm_write  (dm_write),
		.dm_rdata  (dm_rdata),
		.wb_we     (wb_we),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data)
	);

	bind mips_pipe mips_pipe_asserts u_asserts (
		.clock     (clock),
		.arst_n    (arst_n),
		.hazard    (hazard),
		.dm_read   (dm_read),
		.dm_write  (dm_write),
		.wb_we     (wb_we),
		.wb_addr   (wb_addr),
		.imem_addr (imem_addr)
	);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	// Past the program end the core fetches no-ops.
	assign imem_data = (int'(imem_addr[31:2]) < prog_len) ? prog[imem_addr[7:2]] : '0;
	assign dm_rdata  = data_mem[dm_addr[5:2]];

	// **************************************************
	// Stimulus helpers
	// **************************************************

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic mips_pipe_pkg::word_t rand_bits(input int n);
		mips_pipe_pkg::word_t r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic mips_pipe_pkg::reg_addr_t pick_reg(input int nregs);
		int v;
		v = int'(rand_bits(3)) % nregs;
		return mips_pipe_pkg::reg_addr_t'(v + 1);
	endfunction

	function automatic mips_pipe_pkg::funct_t rand_funct();
		int k;
		k = int'(rand_bits(3)) % 5;
		case (k)
			0: return mips_pipe_pkg::FN_ADDU;
			1: return mips_pipe_pkg::FN_SUBU;
			2: return mips_pipe_pkg::FN_AND;
			3: return mips_pipe_pkg::FN_OR;
			default: return mips_pipe_pkg::FN_SLT;
		endcase
	endfunction

	function automatic mips_pipe_pkg::word_t encode_rtype(input mips_pipe_pkg::funct_t fn,
		input mips_pipe_pkg::reg_addr_t rs, input mips_pipe_pkg::reg_addr_t rt,
		input mips_pipe_pkg::reg_addr_t rd);
		return {mips_pipe_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic mips_pipe_pkg::word_t encode_itype(input mips_pipe_pkg::opcode_t op,
		input mips_pipe_pkg::reg_addr_t rs, input mips_pipe_pkg::reg_addr_t rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic build_program(input logic [7:0] mix, input int len, input int nregs);
		logic [2:0]               cls;
		mips_pipe_pkg::reg_addr_t rs;
		mips_pipe_pkg::reg_addr_t rt;
		int                       off;
		prog_len = len;
		for (int i = 0; i < MAX_LEN; i++) begin
			prog[i] = '0;
		end
		// Seed r1 to r7 first.
		for (int i = 0; i < 7; i++) begin
			prog[i] = encode_itype(mips_pipe_pkg::OP_ADDIU, '0,
				mips_pipe_pkg::reg_addr_t'(i + 1), 16'(rand_bits(16)));
		end
		for (int i = 7; i < len; i++) begin
			rs = pick_reg(nregs);
			rt = pick_reg(nregs);
			cls = 3'(rand_bits(3));
			while (!mix[cls]) begin
				cls = 3'(rand_bits(3));
			end
			case (cls)
				3'd0: prog[i] = encode_rtype(rand_funct(), rs, rt, pick_reg(nregs));
				3'd1: prog[i] = encode_itype(mips_pipe_pkg::OP_ADDIU, rs, rt, 16'(rand_bits(16)));
				3'd2: prog[i] = encode_itype(mips_pipe_pkg::OP_LUI, '0, rt, 16'(rand_bits(16)));
				3'd3: prog[i] = encode_itype(mips_pipe_pkg::OP_LW, rs, rt, 16'(rand_bits(4) << 2));
				3'd4: prog[i] = encode_itype(mips_pipe_pkg::OP_SW, rs, rt, 16'(rand_bits(4) << 2));
				default: begin
					if (rand_bits(1) == 1) begin
						rt = rs;
					end
					// Forward only and never past the program end.
					off = int'(rand_bits(2));
					if (i + 1 + off > len) begin
						off = len - 1 - i;
					end
					prog[i] = encode_itype(mips_pipe_pkg::OP_BEQ, rs, rt, 16'(off));
				end
			endcase
		end
	endtask

	// **************************************************
	// Instruction-level model
	// **************************************************

	task automatic run_model();
		mips_pipe_pkg::word_t     regs [32];
		mips_pipe_pkg::word_t     mem [16];
		mips_pipe_pkg::word_t     ins;
		mips_pipe_pkg::word_t     a;
		mips_pipe_pkg::word_t     b;
		mips_pipe_pkg::word_t     imm;
		mips_pipe_pkg::word_t     addr;
		mips_pipe_pkg::word_t     res;
		mips_pipe_pkg::reg_addr_t dest;
		logic                     writes;
		int                       pc;
		foreach (regs[i]) begin
			regs[i] = '0;
		end
		foreach (mem[i]) begin
			mem[i] = data_init[i];
		end
		exp_wb_addr.delete();
		exp_wb_data.delete();
		exp_st_addr.delete();
		exp_st_data.delete();
		exp_ld_addr.delete();
		pc = 0;
		while (pc < prog_len) begin
			ins = prog[pc];
			pc++;
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			addr = a + imm;
			dest = ins[20:16];
			writes = 1'b1;
			res = '0;
			case (ins[31:26])
				mips_pipe_pkg::OP_RTYPE: begin
					dest = ins[15:11];
					case (ins[5:0])
						mips_pipe_pkg::FN_ADDU: res = a + b;
						mips_pipe_pkg::FN_SUBU: res = a - b;
						mips_pipe_pkg::FN_AND:  res = a & b;
						mips_pipe_pkg::FN_OR:   res = a | b;
						default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					endcase
				end
				mips_pipe_pkg::OP_ADDIU: res = a + imm;
				mips_pipe_pkg::OP_LUI:   res = {ins[15:0], 16'h0000};
				mips_pipe_pkg::OP_LW: begin
					res = mem[addr[5:2]];
					exp_ld_addr.push_back(addr);
				end
				mips_pipe_pkg::OP_SW: begin
					writes = 1'b0;
					mem[addr[5:2]] = b;
					exp_st_addr.push_back(addr);
					exp_st_data.push_back(b);
				end
				mips_pipe_pkg::OP_BEQ: begin
					writes = 1'b0;
					if (a == b) begin
						pc = pc + int'($signed(imm));
					end
				end
				default: writes = 1'b0;
			endcase
			if (writes && dest != '0) begin
				regs[dest] = res;
				exp_wb_addr.push_back(dest);
				exp_wb_data.push_back(res);
			end
		end
	endtask

	// **************************************************
	// Checks and event monitor
	// **************************************************

	task automatic check_word(input string name, input mips_pipe_pkg::word_t exp,
		input mips_pipe_pkg::word_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_reg_addr(input string name, input mips_pipe_pkg::reg_addr_t exp,
		input mips_pipe_pkg::reg_addr_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected r%0d actual r%0d", name, exp, act);
			errors++;
		end
	endtask

	// Events count only in cycles where run is high.
	always @(posedge clock) begin
		if (!arst_n) begin
			wb_seen = 0;
			st_seen = 0;
			ld_seen = 0;
			for (int k = 0; k < 16; k++) begin
				data_mem[k] = data_init[k];
			end
		end else if (run) begin
			cycles++;
			if (wb_we) begin
				if (wb_seen < exp_wb_addr.size()) begin
					check_reg_addr(test_name, exp_wb_addr[wb_seen], wb_addr);
					check_word(test_name, exp_wb_data[wb_seen], wb_data);
				end else begin
					$display("%s: unexpected register write to r%0d", test_name, wb_addr);
					errors++;
				end
				wb_seen++;
			end
			if (dm_read) begin
				if (ld_seen < exp_ld_addr.size()) begin
					check_word(test_name, exp_ld_addr[ld_seen], dm_addr);
				end else begin
					$display("%s: unexpected load from address %h", test_name, dm_addr);
					errors++;
				end
				ld_seen++;
			end
			if (dm_write) begin
				if (st_seen < exp_st_addr.size()) begin
					check_word(test_name, exp_st_addr[st_seen], dm_addr);
					check_word(test_name, exp_st_data[st_seen], dm_wdata);
				end else begin
					$display("%s: unexpected store to address %h", test_name, dm_addr);
					errors++;
				end
				st_seen++;
				data_mem[dm_addr[5:2]] = dm_wdata;
			end
			if (cycles > limit) begin
				$display("Timeout after %0d running cycles, events still missing", cycles);
				$display("SOME TESTS FAILED");
				$finish;
			end
		end
	end

	// **************************************************
	// Test sequence
	// **************************************************

	initial begin
		int  errors_before;
		int  end_before;
		int  tests_failed;
		logic failed;
		arst_n = 1'b0;
		run = 1'b0;
		lfsr_state = 32'ha44c_2afc;
		tests_failed = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			limit += 5 * LENS[t] + 20;
		end
		for (int t = 0; t < NUM_TESTS; t++) begin
			@(posedge clock);
			arst_n <= 1'b0;
			run <= 1'b1;
			@(posedge clock);
			case (t)
				0: test_name = "alu_reg";
				1: test_name = "imm_ops";
				2: test_name = "load_store";
				3: test_name = "raw_dense";
				4: test_name = "branch";
				default: test_name = "run_toggle";
			endcase
			build_program(MIXES[t], LENS[t], NREGS[t]);
			for (int k = 0; k < 16; k++) begin
				data_init[k] = rand_bits(32);
			end
			run_model();
			errors_before = errors;
			end_before = end_errors;
			repeat (10) @(posedge clock);
			arst_n <= 1'b1;
			while (wb_seen < exp_wb_addr.size() || st_seen < exp_st_addr.size()) begin
				@(posedge clock);
				if (t == NUM_TESTS - 1) begin
					run <= (rand_bits(2) != 0);
				end
				@(negedge clock);
			end
			// Drain so that late extra events still show up.
			@(posedge clock);
			run <= 1'b1;
			repeat (12) @(posedge clock);
			@(negedge clock);
			if (wb_seen != exp_wb_addr.size() || st_seen != exp_st_addr.size() ||
				ld_seen != exp_ld_addr.size()) begin
				$display("%s: %0d writes, %0d stores and %0d loads seen, %0d, %0d and %0d expected",
					test_name, wb_seen, st_seen, ld_seen, exp_wb_addr.size(),
					exp_st_addr.size(), exp_ld_addr.size());
				end_errors++;
			end
			failed = (errors != errors_before) || (end_errors != end_before);
			if (failed) begin
				tests_failed++;
			end
			$display("test %0d %s: %s, %0d writes, %0d stores", t + 1, test_name,
				failed ? "failed" : "ok", wb_seen, st_seen);
		end
		$display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, tests_failed,
			errors + end_errors);
		if (tests_failed == 0 && errors == 0 && end_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end
endmodule

`default_nettype wire

// ==== mips_pipe.f ====
+incdir+rtl
rtl/mips_pipe_pkg.sv
rtl/pipe_control.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/decode_unit.sv
rtl/exec_unit.sv
rtl/pipe_regwalls.sv
rtl/mips_pipe.sv
tests/mips_pipe_asserts.sv
tests/mips_pipe_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mips_pipe_tb
FILELIST = mips_pipe.f
BUILD    = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(BUILD)
